// File: src/calc_pkg.sv
// ----------------------------------------------------------
// shared types, ascii codes, bit timing and fsm encodings
// for the serial calculator; modules pull it in by a
// wildcard import in their headers
// ----------------------------------------------------------
package calc_pkg;

    // ------------------------------------------------------
    // data widths
    // ------------------------------------------------------
    typedef logic [7:0] byte_t;    // one serial character
    typedef logic [3:0] nibble_t;  // operand from low half of a digit
    typedef logic [4:0] result_t;  // sum or difference, carry/borrow in msb

    // ------------------------------------------------------
    // bit timing
    // ------------------------------------------------------
    localparam int TICKS_PER_CLK_DIV = 4;   // CLKOP cycles per oversample tick
    localparam int OVERSAMPLE        = 16;  // ticks per serial bit
    localparam int DIV_W             = $clog2(TICKS_PER_CLK_DIV);
    localparam int OS_W              = $clog2(OVERSAMPLE);

    localparam logic [OS_W-1:0] OS_LAST = OS_W'(OVERSAMPLE - 1);     // last tick of a bit
    localparam logic [OS_W-1:0] OS_MID  = OS_W'(OVERSAMPLE / 2 - 1); // start bit centre

    // ------------------------------------------------------
    // character codes
    // ------------------------------------------------------
    localparam nibble_t    DIGIT_HI    = 4'h3;   // '0'..'?' share this upper nibble
    localparam byte_t      ASCII_PLUS  = 8'h2B;  // '+'
    localparam byte_t      ASCII_MINUS = 8'h2D;  // '-'
    localparam logic [2:0] RESULT_BASE = 3'b010; // result lands in '@'..'_'

    // ------------------------------------------------------
    // state machines
    // ------------------------------------------------------
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    typedef enum logic [1:0] {
        ENG_WAIT_A,   // first operand
        ENG_WAIT_B,   // second operand
        ENG_WAIT_OP   // '+' or '-'
    } eng_state_t;

endpackage

// File: src/calc_out_if.sv
// ----------------------------------------------------------
// echo and result strobes from the command engine to the
// transmit arbiter; data is valid only in the strobe cycle
// ----------------------------------------------------------
`timescale 1ns/1ps

interface calc_out_if
    import calc_pkg::*;
();

    logic  o_echo;          // one-cycle echo strobe
    byte_t o_echo_data;     // byte to echo back
    logic  o_result_valid;  // one-cycle result strobe
    byte_t o_result_data;   // ascii coded result

    modport engine (
        output o_echo, o_echo_data, o_result_valid, o_result_data
    );

    modport arbiter (
        input o_echo, o_echo_data, o_result_valid, o_result_data
    );

endinterface

// File: src/baud_tick_gen.sv
// ----------------------------------------------------------
// oversample tick enable, one CLKOP pulse every
// TICKS_PER_CLK_DIV cycles, shared by receiver and transmitter
// ----------------------------------------------------------
`timescale 1ns/1ps

module baud_tick_gen
    import calc_pkg::*;
(
    input  logic CLKOP,
    input  logic i_rst,
    output logic o_tick
);

    logic [DIV_W-1:0] div_cnt;  // free running divider

    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            div_cnt <= '0;
            o_tick  <= 1'b0;
        end else begin
            if (div_cnt == DIV_W'(TICKS_PER_CLK_DIV - 1)) begin
                div_cnt <= '0;
                o_tick  <= 1'b1;  // wrap marks the tick
            end else begin
                div_cnt <= div_cnt + 1'b1;
                o_tick  <= 1'b0;
            end
        end
    end

endmodule

// File: src/uart_rx.sv
// ----------------------------------------------------------
// 8N1 receiver, 16x oversampled on the tick enable
// start bit re-checked at its centre, data lsb first
// strobe only when the stop bit samples high
// ----------------------------------------------------------
`timescale 1ns/1ps

module uart_rx
    import calc_pkg::*;
(
    input  logic  CLKOP,
    input  logic  i_rst,
    input  logic  i_tick,
    input  logic  i_serial,
    output logic  o_valid,
    output byte_t o_data
);

    logic            rx_meta;   // first sync stage
    logic            rx_sync;   // line as seen by the fsm
    rx_state_t       state;
    logic [OS_W-1:0] os_cnt;    // ticks inside the current bit
    logic [2:0]      bit_idx;   // data bit being received
    byte_t           shreg;     // incoming bits, lsb first
    logic            bit_done;  // tick at the centre of a data or stop bit

    assign bit_done = i_tick && (os_cnt == OS_LAST);

    // ------------------------------------------------------
    // control path
    // ------------------------------------------------------
    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            rx_meta <= 1'b1;  // idle line is high
            rx_sync <= 1'b1;
            state   <= RX_IDLE;
            os_cnt  <= '0;
            bit_idx <= '0;
            o_valid <= 1'b0;
        end else begin
            rx_meta <= i_serial;
            rx_sync <= rx_meta;
            o_valid <= 1'b0;  // strobe lasts one clock
            if (i_tick) begin
                case (state)
                    RX_IDLE: begin
                        if (!rx_sync) begin  // falling edge, maybe a start bit
                            state  <= RX_START;
                            os_cnt <= '0;
                        end
                    end
                    RX_START: begin
                        if (os_cnt == OS_MID) begin
                            os_cnt  <= '0;
                            bit_idx <= '0;
                            // glitch if the line went back high
                            state   <= rx_sync ? RX_IDLE : RX_DATA;
                        end else begin
                            os_cnt <= os_cnt + 1'b1;
                        end
                    end
                    RX_DATA: begin
                        if (os_cnt == OS_LAST) begin
                            os_cnt  <= '0;
                            bit_idx <= bit_idx + 3'd1;
                            if (bit_idx == 3'd7) begin
                                state <= RX_STOP;
                            end
                        end else begin
                            os_cnt <= os_cnt + 1'b1;
                        end
                    end
                    RX_STOP: begin
                        if (os_cnt == OS_LAST) begin
                            os_cnt  <= '0;
                            o_valid <= rx_sync;  // low stop bit, frame dropped
                            state   <= RX_IDLE;
                        end else begin
                            os_cnt <= os_cnt + 1'b1;
                        end
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

    // ------------------------------------------------------
    // data path
    // ------------------------------------------------------
    always_ff @(posedge CLKOP) begin
        if (bit_done && state == RX_DATA) begin
            shreg <= {rx_sync, shreg[7:1]};  // lsb arrives first
        end
        if (bit_done && state == RX_STOP && rx_sync) begin
            o_data <= shreg;  // held until the next good frame
        end
    end

endmodule

// File: src/calc_engine.sv
// ----------------------------------------------------------
// command engine: echoes every received byte and watches
// for digit, digit, operator; on '+' or '-' it sends the
// 5-bit result as one ascii byte next to the operator echo
// ----------------------------------------------------------
`timescale 1ns/1ps

module calc_engine
    import calc_pkg::*;
(
    input  logic  CLKOP,
    input  logic  i_rst,
    input  logic  i_valid,
    input  byte_t i_data,
    calc_out_if.engine cout
);

    eng_state_t state;
    nibble_t    op_a;      // first operand
    nibble_t    op_b;      // second operand
    result_t    sum_res;
    result_t    diff_res;
    logic       is_digit;
    logic       is_op;     // '+' or '-'

    assign is_digit = (i_data[7:4] == DIGIT_HI);
    assign is_op    = (i_data == ASCII_PLUS) || (i_data == ASCII_MINUS);

    // ------------------------------------------------------
    // add/subtract unit, carry or borrow kept in bit 4
    // ------------------------------------------------------
    always_comb begin
        sum_res  = {1'b0, op_a} + {1'b0, op_b};
        diff_res = {1'b0, op_a} - {1'b0, op_b};  // wraps modulo 32
    end

    // ------------------------------------------------------
    // sequencer
    // ------------------------------------------------------
    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            state               <= ENG_WAIT_A;
            cout.o_echo         <= 1'b0;
            cout.o_result_valid <= 1'b0;
        end else begin
            cout.o_echo         <= i_valid;  // every good byte goes back
            cout.o_result_valid <= 1'b0;
            if (i_valid) begin
                case (state)
                    ENG_WAIT_A: state <= is_digit ? ENG_WAIT_B : ENG_WAIT_A;
                    ENG_WAIT_B: state <= is_digit ? ENG_WAIT_OP : ENG_WAIT_A;
                    ENG_WAIT_OP: begin
                        cout.o_result_valid <= is_op;  // other bytes just restart
                        state               <= ENG_WAIT_A;
                    end
                    default: state <= ENG_WAIT_A;
                endcase
            end
        end
    end

    // operands and outgoing bytes
    always_ff @(posedge CLKOP) begin
        if (i_valid) begin
            cout.o_echo_data <= i_data;
            if (state == ENG_WAIT_A && is_digit) begin
                op_a <= i_data[3:0];
            end
            if (state == ENG_WAIT_B && is_digit) begin
                op_b <= i_data[3:0];
            end
            if (state == ENG_WAIT_OP) begin
                // '@' plus result
                cout.o_result_data <= {RESULT_BASE,
                                       (i_data == ASCII_MINUS) ? diff_res : sum_res};
            end
        end
    end

endmodule

// File: src/tx_arbiter.sv
// ----------------------------------------------------------
// shares the one transmitter between echo and result
// echo wins; a result waits for an idle transmitter and no
// echo pending, so it always follows the operator echo
// ----------------------------------------------------------
`timescale 1ns/1ps

module tx_arbiter
    import calc_pkg::*;
(
    input  logic  CLKOP,
    input  logic  i_rst,
    calc_out_if.arbiter cin,
    input  logic  i_busy,
    output logic  o_start,
    output byte_t o_data
);

    logic  echo_pend;  // echo waiting for the transmitter
    logic  res_pend;   // result waiting behind it
    byte_t echo_buf;
    byte_t res_buf;
    logic  tx_free;    // transmitter can take a byte this cycle

    // busy rises one clock after start, so skip the cycle after a start
    assign tx_free = !i_busy && !o_start;

    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            echo_pend <= 1'b0;
            res_pend  <= 1'b0;
            o_start   <= 1'b0;
        end else begin
            o_start <= 1'b0;
            if (tx_free && echo_pend) begin
                o_start   <= 1'b1;
                echo_pend <= 1'b0;
            end else if (tx_free && res_pend) begin
                o_start  <= 1'b1;
                res_pend <= 1'b0;
            end
            // new strobes win over the clear above
            if (cin.o_echo) begin
                echo_pend <= 1'b1;
            end
            if (cin.o_result_valid) begin
                res_pend <= 1'b1;
            end
        end
    end

    // byte buffers and transmit data
    always_ff @(posedge CLKOP) begin
        if (cin.o_echo) begin
            echo_buf <= cin.o_echo_data;  // a newer echo overwrites
        end
        if (cin.o_result_valid) begin
            res_buf <= cin.o_result_data;
        end
        if (tx_free && echo_pend) begin
            o_data <= echo_buf;
        end else if (tx_free && res_pend) begin
            o_data <= res_buf;
        end
    end

endmodule

// File: src/uart_tx.sv
// ----------------------------------------------------------
// 8N1 transmitter paced by the oversample tick
// byte latched on start, busy until the stop bit ends
// ----------------------------------------------------------
`timescale 1ns/1ps

module uart_tx
    import calc_pkg::*;
(
    input  logic  CLKOP,
    input  logic  i_rst,
    input  logic  i_tick,
    input  logic  i_start,
    input  byte_t i_data,
    output logic  o_serial,
    output logic  o_busy
);

    tx_state_t       state;
    logic [OS_W-1:0] os_cnt;    // ticks spent in the current bit
    logic [2:0]      bit_idx;   // data bit on the line
    byte_t           shreg;     // bits still to send
    logic            bit_end;   // last tick of the current bit

    assign bit_end = i_tick && (os_cnt == OS_LAST);

    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            state    <= TX_IDLE;
            os_cnt   <= '0;
            bit_idx  <= '0;
            o_serial <= 1'b1;  // line idles high
            o_busy   <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (i_start) begin
                        state    <= TX_START;
                        os_cnt   <= '0;
                        o_serial <= 1'b0;  // start bit
                        o_busy   <= 1'b1;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state    <= TX_DATA;
                        bit_idx  <= '0;
                        o_serial <= shreg[0];  // lsb first
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state    <= TX_STOP;
                            o_serial <= 1'b1;
                        end else begin
                            o_serial <= shreg[1];  // next bit before the shift
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        state  <= TX_IDLE;
                        o_busy <= 1'b0;  // free again
                    end
                end
                default: state <= TX_IDLE;
            endcase
            if (state != TX_IDLE && i_tick) begin
                os_cnt <= os_cnt + 1'b1;  // wraps to 0 at each bit end
            end
        end
    end

    // shift register, loaded on start
    always_ff @(posedge CLKOP) begin
        if (state == TX_IDLE && i_start) begin
            shreg <= i_data;
        end else if (state == TX_DATA && bit_end) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

endmodule

// File: src/calc_uart_top.sv
// ----------------------------------------------------------
// serial calculator top level on CLKOP
// rx -> engine -> arbiter -> tx, all paced by one tick
// ----------------------------------------------------------
`timescale 1ns/1ps

module calc_uart_top
    import calc_pkg::*;
(
    input  logic CLKOP,
    input  logic i_rst,
    input  logic i_serial_data,   // from host
    output logic o_serial_data    // to host
);

    logic  tick;       // oversample enable
    logic  rx_valid;   // good byte received
    byte_t rx_data;
    logic  tx_start;   // arbiter kicks the transmitter
    byte_t tx_data;
    logic  tx_busy;

    calc_out_if u_out_if ();  // engine to arbiter strobes

    baud_tick_gen u_tick (
        .CLKOP  (CLKOP),
        .i_rst  (i_rst),
        .o_tick (tick)
    );

    uart_rx u_rx (
        .CLKOP    (CLKOP),
        .i_rst    (i_rst),
        .i_tick   (tick),
        .i_serial (i_serial_data),
        .o_valid  (rx_valid),
        .o_data   (rx_data)
    );

    calc_engine u_eng (
        .CLKOP   (CLKOP),
        .i_rst   (i_rst),
        .i_valid (rx_valid),
        .i_data  (rx_data),
        .cout    (u_out_if.engine)
    );

    tx_arbiter u_arb (
        .CLKOP   (CLKOP),
        .i_rst   (i_rst),
        .cin     (u_out_if.arbiter),
        .i_busy  (tx_busy),
        .o_start (tx_start),
        .o_data  (tx_data)
    );

    uart_tx u_tx (
        .CLKOP    (CLKOP),
        .i_rst    (i_rst),
        .i_tick   (tick),
        .i_start  (tx_start),
        .i_data   (tx_data),
        .o_serial (o_serial_data),
        .o_busy   (tx_busy)
    );

endmodule

// File: dv/calc_sva.sv
// ----------------------------------------------------------
// assertions bound into the calculator top level: idle
// line around reset, transmitter start rules and results
// riding on an echo strobe
// ----------------------------------------------------------
`timescale 1ns/1ps

module calc_sva (
    input logic CLKOP,
    input logic i_rst,
    input logic i_serial_out,
    input logic i_tx_start,
    input logic i_tx_busy,
    input logic i_echo,
    input logic i_result
);

    // high from the second reset edge until one cycle after release
    a_idle_in_reset: assert property (@(posedge CLKOP) $past(i_rst) |-> i_serial_out)
        else $error("serial output low during or right after reset");

    a_start_when_free: assert property (@(posedge CLKOP) disable iff (i_rst)
        i_tx_start |-> !i_tx_busy)
        else $error("transmit start issued while the transmitter was busy");

    a_busy_after_start: assert property (@(posedge CLKOP) disable iff (i_rst)
        i_tx_start |=> i_tx_busy)  // busy follows one clock later
        else $error("transmitter did not go busy after start");

    a_result_with_echo: assert property (@(posedge CLKOP) disable iff (i_rst)
        i_result |-> i_echo)
        else $error("result strobe without an echo strobe");

endmodule

bind calc_uart_top calc_sva u_sva (
    .CLKOP        (CLKOP),
    .i_rst        (i_rst),
    .i_serial_out (o_serial_data),
    .i_tx_start   (tx_start),
    .i_tx_busy    (tx_busy),
    .i_echo       (u_out_if.o_echo),
    .i_result     (u_out_if.o_result_valid)
);

// File: dv/calc_tb.sv
// ----------------------------------------------------------
// testbench for the serial calculator: drives 8N1 frames
// into the DUT, decodes the serial output and checks it
// against a byte model of the echo and result rules
// ----------------------------------------------------------
`timescale 1ns/1ps

module calc_tb
    import calc_pkg::*;
();

    localparam int BIT_CLKS    = OVERSAMPLE * TICKS_PER_CLK_DIV;  // clocks per serial bit
    localparam int FRAME_CLKS  = 10 * BIT_CLKS;
    localparam int N_RAND      = 20;                              // random triples per op
    localparam int TOTAL_BYTES = 4 + 3 + 3 * N_RAND + 6 + 3 * N_RAND + 8 + 4;
    localparam longint WATCHDOG_NS = longint'(TOTAL_BYTES) * 2 * FRAME_CLKS * 100 * 2;

    logic        CLKOP;
    logic        i_rst;
    logic        i_serial_data;
    logic        o_serial_data;
    byte_t       got_q[$];     // decoded from o_serial_data
    byte_t       exp_q[$];     // predicted output
    logic [31:0] rng_state;
    int          n_err;
    int          n_fail;
    int          n_test;
    int          err_at_start;
    int          mdl_digits;   // model: digits seen in a row, 0..2
    nibble_t     mdl_a;
    nibble_t     mdl_b;

    calc_uart_top dut (
        .CLKOP         (CLKOP),
        .i_rst         (i_rst),
        .i_serial_data (i_serial_data),
        .o_serial_data (o_serial_data)
    );

    initial begin
        CLKOP = 1'b0;
        forever #50 CLKOP = ~CLKOP;  // 100 ns period
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the tests did not finish in time");
        $display("Some tests failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ------------------------------------------------------
    // reference model of the byte stream
    // ------------------------------------------------------
    task automatic predict(input byte_t b);
        int r;
        exp_q.push_back(b);  // every good byte echoes
        if (mdl_digits == 2) begin
            if (b == ASCII_PLUS || b == ASCII_MINUS) begin
                r = (b == ASCII_PLUS) ? int'(mdl_a) + int'(mdl_b) : int'(mdl_a) - int'(mdl_b);
                exp_q.push_back(byte_t'(8'h40 + (r & 31)));  // '@' plus result mod 32
            end
            mdl_digits = 0;  // any third byte restarts
        end else if (b[7:4] == DIGIT_HI) begin
            if (mdl_digits == 0) begin
                mdl_a = b[3:0];
            end else begin
                mdl_b = b[3:0];
            end
            mdl_digits++;
        end else begin
            mdl_digits = 0;
        end
    endtask

    // ------------------------------------------------------
    // serial driver and monitor
    // ------------------------------------------------------
    task automatic send_frame(input byte_t b, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, b, 1'b0};  // lsb first on the wire
        if (stop_bit) predict(b);     // bad frames leave the model alone
        @(posedge CLKOP);
        for (int i = 0; i < 10; i++) begin
            i_serial_data <= frame[i];
            repeat (BIT_CLKS) @(posedge CLKOP);
        end
        if (!stop_bit) begin
            i_serial_data <= 1'b1;
            repeat (FRAME_CLKS) @(posedge CLKOP);  // idle long enough to drop the false start
        end
    endtask

    task automatic send_text(input string s);
        for (int i = 0; i < s.len(); i++) begin
            send_frame(s[i], 1'b1);
        end
    endtask

    initial begin : monitor
        byte_t rx;
        @(negedge CLKOP);
        wait (!i_rst);
        forever begin
            @(negedge CLKOP);
            if (!o_serial_data) begin
                repeat (BIT_CLKS / 2) @(negedge CLKOP);  // start bit centre
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CLKS) @(negedge CLKOP);
                    rx[i] = o_serial_data;
                end
                repeat (BIT_CLKS) @(negedge CLKOP);
                assert (o_serial_data) got_q.push_back(rx);
                else begin
                    $display("framing error on o_serial_data, stop bit was low");
                    n_err++;
                end
            end
        end
    end

    // ------------------------------------------------------
    // test helpers
    // ------------------------------------------------------
    task automatic wait_for_bytes(input int n);
        int cnt;
        cnt = 0;
        while (got_q.size() < n && cnt < 4 * FRAME_CLKS) begin
            @(negedge CLKOP);
            cnt++;
        end
        assert (got_q.size() >= n)
        else begin
            $display("timed out waiting for %0d output bytes, only %0d came", n, got_q.size());
            n_err++;
        end
    endtask

    task automatic random_triple(input byte_t op);
        rng_state = xorshift32(rng_state);
        send_frame({DIGIT_HI, rng_state[3:0]}, 1'b1);
        send_frame({DIGIT_HI, rng_state[11:8]}, 1'b1);
        send_frame(op, 1'b1);
        wait_for_bytes(exp_q.size());  // drain before the next triple
    endtask

    task automatic begin_test();
        got_q.delete();
        exp_q.delete();
        err_at_start = n_err;
    endtask

    task automatic end_test(input string name);
        wait_for_bytes(exp_q.size());
        repeat (2 * FRAME_CLKS) @(negedge CLKOP);  // nothing extra may follow
        assert (got_q.size() == exp_q.size())
        else begin
            $display("wrong output byte count: expected %0d, got %0d",
                     exp_q.size(), got_q.size());
            n_err++;
        end
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            assert (got_q[i] == exp_q[i])
            else begin
                $display("MISMATCH o_serial_data byte %0d: expected 0x%02h, got 0x%02h",
                         i, exp_q[i], got_q[i]);
                n_err++;
            end
        end
        n_test++;
        if (n_err > err_at_start) n_fail++;
        $display("test %0d %s: %s", n_test, name, (n_err > err_at_start) ? "FAIL" : "ok");
    endtask

    // ------------------------------------------------------
    // test sequence
    // ------------------------------------------------------
    initial begin
        i_rst         = 1'b1;
        i_serial_data = 1'b1;  // idle line
        rng_state     = 32'h5a6f_15e7;
        n_err         = 0;
        n_fail        = 0;
        n_test        = 0;
        err_at_start  = 0;
        mdl_digits    = 0;
        mdl_a         = '0;
        mdl_b         = '0;
        repeat (8) @(posedge CLKOP);
        i_rst <= 1'b0;

        begin_test();
        end_test("idle after reset");

        begin_test();
        send_text("x");
        wait_for_bytes(exp_q.size());
        send_text("A");
        wait_for_bytes(exp_q.size());
        send_text("+");
        wait_for_bytes(exp_q.size());
        send_text(" ");
        end_test("single byte echo");

        begin_test();
        send_text("35+");
        wait_for_bytes(exp_q.size());
        for (int k = 0; k < N_RAND; k++) random_triple(ASCII_PLUS);
        end_test("addition");

        begin_test();
        send_text("72-");
        wait_for_bytes(exp_q.size());
        send_text("27-");  // borrow case
        wait_for_bytes(exp_q.size());
        for (int k = 0; k < N_RAND; k++) random_triple(ASCII_MINUS);
        end_test("subtraction");

        begin_test();
        send_text("4a61+");
        wait_for_bytes(exp_q.size());
        send_text("45x");
        end_test("interrupted sequence");

        begin_test();
        send_frame("3", 1'b1);
        send_frame("8", 1'b0);  // low stop bit, dropped
        send_frame("4", 1'b1);
        send_frame("+", 1'b1);
        end_test("bad stop bit");

        $display("summary: %0d tests, %0d failing, %0d errors", n_test, n_fail, n_err);
        if (n_err == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: files.f
src/calc_pkg.sv
src/calc_out_if.sv
src/baud_tick_gen.sv
src/uart_rx.sv
src/calc_engine.sv
src/tx_arbiter.sv
src/uart_tx.sv
src/calc_uart_top.sv
dv/calc_sva.sv
dv/calc_tb.sv

// File: run.sh
#!/bin/sh
# build the serial calculator testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module calc_tb -o calc_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/calc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    exit 1
fi
exit 0
